/* project.f */
+incdir+logic
logic/execLanePkg.sv
logic/ringBufferControl.sv
logic/resultQueue.sv
logic/addUnit.sv
logic/mulUnit.sv
logic/writebackArbiter.sv
logic/registerFile.sv
logic/execLane.sv
verif/execLaneTb.sv

/* verif/execLaneTb.sv */
`default_nettype none
`include "execLane_macros.svh"

module execLaneTb
	import execLanePkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int readyTimeout = 64;	// Cycles a unit may stay busy
	localparam int drainTimeout = 256;

	logic clock;
	logic reset;
	logic issue;
	opCode_t opCode;
	index_t dstIndex;
	index_t srcIndex1;
	index_t srcIndex2;
	data_t immediate;
	logic addBusy;
	logic mulBusy;
	logic writeValid;
	index_t writeIndex;
	data_t writeData;

	logic [31:0] seed = 32'hfa5c;
	string testName;
	int mismatchCount;
	int otherErrorCount;
	int issuedCount;
	int retiredCount;

	// Model state
	data_t modelRegs [`REG_COUNT];
	data_t addExpData [$];
	index_t addExpIndex [$];
	data_t mulExpData [$];
	index_t mulExpIndex [$];

	execLane dut0 (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.opCode(opCode),
		.dstIndex(dstIndex),
		.srcIndex1(srcIndex1),
		.srcIndex2(srcIndex2),
		.immediate(immediate),
		.addBusy(addBusy),
		.mulBusy(mulBusy),
		.writeValid(writeValid),
		.writeIndex(writeIndex),
		.writeData(writeData)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic checkData(input data_t expected, input data_t actual);
		if (expected !== actual) begin
			mismatchCount++;
			$display("Mismatch in %s: writeData expected %h, got %h",
				testName, expected, actual);
		end
	endtask

	task automatic checkIndex(input index_t expected, input index_t actual);
		if (expected !== actual) begin
			mismatchCount++;
			$display("Mismatch in %s: writeIndex expected %0d, got %0d",
				testName, expected, actual);
		end
	endtask

	////////////////////
	// Drivers

	task automatic stepCycle();
		@(posedge clock);
		#2;
	endtask

	task automatic issueCommand(input opCode_t op, input index_t dst, input index_t src1,
		input index_t src2, input data_t imm);
		opCode = op;
		dstIndex = dst;
		srcIndex1 = src1;
		srcIndex2 = src2;
		immediate = imm;
		issue = 1'b1;
		stepCycle();
		issue = 1'b0;
	endtask

	task automatic issueRandom(input opCode_t op);
		logic [31:0] fields;
		data_t imm;
		fields = nextRandom();
		imm = nextRandom();
		issueCommand(op, fields[19:16], fields[23:20], fields[27:24], imm);
	endtask

	task automatic waitReady(input logic forMul);
		int waited;
		waited = 0;
		while ((forMul ? mulBusy : addBusy) && waited < readyTimeout) begin
			stepCycle();
			waited++;
		end
		if (forMul ? mulBusy : addBusy) begin
			otherErrorCount++;
			$display("Error in %s: the %s unit stayed busy past the timeout", testName,
				forMul ? "multiply" : "add");
		end
	endtask

	task automatic drainResults();
		int waited;
		waited = 0;
		while ((addExpIndex.size() != 0 || mulExpIndex.size() != 0) && waited < drainTimeout) begin
			stepCycle();
			waited++;
		end
		if (addExpIndex.size() != 0 || mulExpIndex.size() != 0) begin
			otherErrorCount++;
			$display("Error in %s: %0d add and %0d multiply results never written back",
				testName, addExpIndex.size(), mulExpIndex.size());
		end
	endtask

	////////////////////
	// Model sampled at the falling edge

	always @(negedge clock) begin : modelStep
		logic takeMul;
		logic found;
		index_t expIndex;
		data_t expData;
		data_t a;
		data_t b;
		if (!reset) begin
			takeMul = 1'b0;
			found = 1'b1;
			// Retire first so a same-cycle issue sees the bypassed value
			if (writeValid) begin
				if (addExpIndex.size() > 0 && addExpIndex[0] == writeIndex
					&& addExpData[0] == writeData)
					takeMul = 1'b0;
				else if (mulExpIndex.size() > 0 && mulExpIndex[0] == writeIndex
					&& mulExpData[0] == writeData)
					takeMul = 1'b1;
				else if (addExpIndex.size() > 0)
					takeMul = 1'b0;
				else if (mulExpIndex.size() > 0)
					takeMul = 1'b1;
				else
					found = 1'b0;
				if (!found) begin
					otherErrorCount++;
					$display("Error in %s: writeback to register %0d with no command pending",
						testName, writeIndex);
				end else begin
					if (takeMul) begin
						expIndex = mulExpIndex.pop_front();
						expData = mulExpData.pop_front();
					end else begin
						expIndex = addExpIndex.pop_front();
						expData = addExpData.pop_front();
					end
					checkIndex(expIndex, writeIndex);
					checkData(expData, writeData);
					modelRegs[expIndex] = expData;
					retiredCount++;
				end
			end
			if (issue) begin
				if ((opCode == MUL) ? mulBusy : addBusy) begin
					otherErrorCount++;
					$display("Error in %s: command issued to a busy unit", testName);
				end
				a = modelRegs[srcIndex1];
				b = modelRegs[srcIndex2];
				case (opCode)
					ADD: begin
						addExpData.push_back(a + b);
						addExpIndex.push_back(dstIndex);
					end
					SUB: begin
						addExpData.push_back(a - b);
						addExpIndex.push_back(dstIndex);
					end
					LDI: begin
						addExpData.push_back(immediate);
						addExpIndex.push_back(dstIndex);
					end
					default: begin
						expData = a * b;	// Low word of the product
						mulExpData.push_back(expData);
						mulExpIndex.push_back(dstIndex);
					end
				endcase
				issuedCount++;
			end
		end
	end

	////////////////////
	// Stimulus

	initial begin : stimulus
		opCode_t op;
		logic [31:0] value;
		reset = 1'b1;
		issue = 1'b0;
		opCode = ADD;
		dstIndex = '0;
		srcIndex1 = '0;
		srcIndex2 = '0;
		immediate = '0;
		mismatchCount = 0;
		otherErrorCount = 0;
		issuedCount = 0;
		retiredCount = 0;
		testName = "reset";
		for (int r = 0; r < `REG_COUNT; r++)
			modelRegs[r] = '0;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;

		// Idle lane after reset
		repeat (4) begin
			stepCycle();
			if (writeValid || addBusy || mulBusy) begin
				otherErrorCount++;
				$display("Error in %s: writeValid or a busy level is high before any issue",
					testName);
			end
		end

		testName = "seed LDI";
		for (int r = 0; r < `REG_COUNT; r++) begin
			waitReady(1'b0);
			issueCommand(LDI, index_t'(r), '0, '0, nextRandom());
		end
		drainResults();

		testName = "add sub";
		repeat (40) begin
			value = nextRandom();
			waitReady(1'b0);
			issueRandom(value[31] ? SUB : ADD);
		end
		drainResults();

		testName = "mul burst";
		repeat (8) begin	// Each LDI result ties with a product and stalls the multiply queue
			waitReady(1'b1);
			issueRandom(MUL);
			waitReady(1'b1);
			issueRandom(MUL);
			waitReady(1'b0);
			issueRandom(LDI);
		end
		drainResults();

		testName = "mixed random";
		repeat (200) begin
			value = nextRandom();
			op = opCode_t'(value[31:30]);
			if ((op == MUL) ? mulBusy : addBusy)
				stepCycle();	// Skip while the target unit is full
			else
				issueRandom(op);
		end
		drainResults();

		if (issuedCount != retiredCount) begin
			otherErrorCount++;
			$display("Error: %0d commands issued but %0d written back", issuedCount, retiredCount);
		end

		$display("Error counts: %0d mismatches, %0d other errors (%0d issued, %0d retired)",
			mismatchCount, otherErrorCount, issuedCount, retiredCount);
		if (mismatchCount == 0 && otherErrorCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/execLane.sv */
`default_nettype none

module execLane
	import execLanePkg::*;
(
	input logic clock,
	input logic reset,
	input logic issue,
	input opCode_t opCode,
	input index_t dstIndex,
	input index_t srcIndex1,
	input index_t srcIndex2,
	input data_t immediate,
	output logic addBusy,
	output logic mulBusy,
	output logic writeValid,
	output index_t writeIndex,
	output data_t writeData
);

	data_t operand1;
	data_t operand2;

	logic addRequest;
	logic addStall;
	data_t addData;
	index_t addIndex;
	logic mulRequest;
	logic mulStall;
	data_t mulData;
	index_t mulIndex;
	logic addGrant;
	logic mulGrant;

	registerFile registers0 (
		.clock(clock),
		.reset(reset),
		.readIndex1(srcIndex1),
		.readIndex2(srcIndex2),
		.readData1(operand1),
		.readData2(operand2),
		.writeEnable(writeValid),
		.writeIndex(writeIndex),
		.writeData(writeData)
	);

	////////////////////
	// Execution units

	addUnit add0 (
		.clock(clock), .reset(reset),
		.issue(issue), .opCode(opCode), .dstIndex(dstIndex),
		.operand1(operand1), .operand2(operand2), .immediate(immediate),
		.stall(addStall), .busy(addBusy), .request(addRequest),
		.resultData(addData), .resultIndex(addIndex)
	);

	mulUnit mul0 (
		.clock(clock), .reset(reset),
		.issue(issue), .opCode(opCode), .dstIndex(dstIndex),
		.operand1(operand1), .operand2(operand2),
		.stall(mulStall), .busy(mulBusy), .request(mulRequest),
		.resultData(mulData), .resultIndex(mulIndex)
	);

	writebackArbiter arbiter0 (
		.clock(clock),
		.reset(reset),
		.addRequest(addRequest),
		.mulRequest(mulRequest),
		.addStall(addStall),
		.mulStall(mulStall)
	);

	////////////////////
	// Write port mux

	assign addGrant = addRequest & ~addStall;
	assign mulGrant = mulRequest & ~mulStall;
	assign writeValid = addGrant | mulGrant;	// Same cycle as the queue pop
	assign writeIndex = addGrant ? addIndex : mulIndex;
	assign writeData = addGrant ? addData : mulData;

endmodule

`default_nettype wire

/* logic/registerFile.sv */
`default_nettype none
`include "execLane_macros.svh"

module registerFile
	import execLanePkg::*;
(
	input logic clock,
	input logic reset,
	input index_t readIndex1,
	input index_t readIndex2,
	output data_t readData1,
	output data_t readData2,
	input logic writeEnable,
	input index_t writeIndex,
	input data_t writeData
);

	data_t registers [`REG_COUNT];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				registers[i] <= '0;
		end else if (writeEnable) begin
			registers[writeIndex] <= writeData;
		end
	end

	////////////////////
	// Reads see a same-cycle writeback

	assign readData1 = (writeEnable && (writeIndex == readIndex1)) ?
		writeData : registers[readIndex1];
	assign readData2 = (writeEnable && (writeIndex == readIndex2)) ?
		writeData : registers[readIndex2];

endmodule

`default_nettype wire

/* logic/writebackArbiter.sv */
`default_nettype none

module writebackArbiter (
	input logic clock,
	input logic reset,
	input logic addRequest,
	input logic mulRequest,
	output logic addStall,
	output logic mulStall
);

	logic addPriority;	// Add unit wins the next tie
	logic addGrant;
	logic mulGrant;

	// At most one grant per cycle
	assign addGrant = addRequest & (~mulRequest | addPriority);
	assign mulGrant = mulRequest & ~addGrant;

	// Flip priority after every grant so ties alternate
	always_ff @(posedge clock) begin
		if (reset) begin
			addPriority <= 1'b1;
		end else if (addGrant) begin
			addPriority <= 1'b0;
		end else if (mulGrant) begin
			addPriority <= 1'b1;
		end
	end

	// Stalled only while the peer holds the port
	assign addStall = mulGrant;
	assign mulStall = addGrant;

endmodule

`default_nettype wire

/* logic/mulUnit.sv */
`default_nettype none
`include "execLane_macros.svh"

module mulUnit
	import execLanePkg::*;
(
	input logic clock,
	input logic reset,
	input logic issue,
	input opCode_t opCode,
	input index_t dstIndex,
	input data_t operand1,
	input data_t operand2,
	input logic stall,
	output logic busy,
	output logic request,
	output data_t resultData,
	output index_t resultIndex
);

	localparam int occWidth = $clog2(`MUL_QUEUE_DEPTH + `MUL_STAGES + 1);

	logic accept;
	data_t product;
	mulToken_t token;
	mulToken_t headToken;
	logic [$clog2(`MUL_QUEUE_DEPTH+1)-1:0] entryNumber;
	logic [occWidth-1:0] occupancy;

	logic [`MUL_STAGES-1:0] stageValid;
	data_t stageData [`MUL_STAGES];
	index_t stageIndex [`MUL_STAGES];

	assign accept = issue & (opCode == MUL);
	assign product = operand1 * operand2;	// Low 32 bits only

	////////////////////
	// Pipeline, never stalls

	always_ff @(posedge clock) begin
		if (reset) begin
			stageValid <= '0;
		end else begin
			stageValid[0] <= accept;
			for (int i = 1; i < `MUL_STAGES; i++)
				stageValid[i] <= stageValid[i-1];
		end
	end

	always_ff @(posedge clock) begin
		stageData[0] <= product;
		stageIndex[0] <= dstIndex;
		for (int i = 1; i < `MUL_STAGES; i++) begin
			stageData[i] <= stageData[i-1];
			stageIndex[i] <= stageIndex[i-1];
		end
	end

	assign token = '{dstIndex: stageIndex[`MUL_STAGES-1]};

	resultQueue #(
		.depth(`MUL_QUEUE_DEPTH),
		.tokenType(mulToken_t)
	) queue0 (
		.clock(clock),
		.reset(reset),
		.push(stageValid[`MUL_STAGES-1]),
		.pushData(stageData[`MUL_STAGES-1]),
		.pushToken(token),
		.stall(stall),
		.valid(),
		.headData(resultData),
		.headToken(headToken),
		.entryNumber(entryNumber)
	);

	////////////////////
	// Busy reserves queue room for every product in flight

	always_comb begin
		occupancy = occWidth'(entryNumber);
		for (int i = 0; i < `MUL_STAGES; i++)
			occupancy = occupancy + occWidth'(stageValid[i]);
	end

	assign busy = (occupancy >= occWidth'(`MUL_QUEUE_DEPTH));
	assign request = (entryNumber != '0);
	assign resultIndex = headToken.dstIndex;

endmodule

`default_nettype wire

/* logic/addUnit.sv */
`default_nettype none
`include "execLane_macros.svh"

module addUnit
	import execLanePkg::*;
(
	input logic clock,
	input logic reset,
	input logic issue,
	input opCode_t opCode,
	input index_t dstIndex,
	input data_t operand1,
	input data_t operand2,
	input data_t immediate,
	input logic stall,
	output logic busy,
	output logic request,
	output data_t resultData,
	output index_t resultIndex
);

	logic accept;
	data_t result;
	addToken_t token;
	addToken_t headToken;
	logic [$clog2(`ADD_QUEUE_DEPTH+1)-1:0] entryNumber;

	assign accept = issue & (opCode != MUL);	// MUL belongs to the peer unit

	// Sums wrap at 32 bits
	always_comb begin
		case (opCode)
			SUB: result = operand1 - operand2;
			LDI: result = immediate;
			default: result = operand1 + operand2;
		endcase
	end

	assign token = '{dstIndex: dstIndex, opCode: opCode};

	resultQueue #(
		.depth(`ADD_QUEUE_DEPTH),
		.tokenType(addToken_t)
	) queue0 (
		.clock(clock),
		.reset(reset),
		.push(accept),
		.pushData(result),
		.pushToken(token),
		.stall(stall),
		.valid(),
		.headData(resultData),
		.headToken(headToken),
		.entryNumber(entryNumber)
	);

	assign busy = (entryNumber == `ADD_QUEUE_DEPTH);
	assign request = (entryNumber != '0);
	assign resultIndex = headToken.dstIndex;

endmodule

`default_nettype wire

/* logic/resultQueue.sv */
`default_nettype none

module resultQueue
	import execLanePkg::*;
#(
	parameter int depth = 4,
	parameter type tokenType = logic
)(
	input logic clock,
	input logic reset,
	input logic push,
	input data_t pushData,
	input tokenType pushToken,
	input logic stall,
	output logic valid,
	output data_t headData,
	output tokenType headToken,
	output logic [$clog2(depth+1)-1:0] entryNumber
);

	logic [$clog2(depth)-1:0] writeAddress;
	logic [$clog2(depth)-1:0] readAddress;
	logic full;
	logic empty;
	logic write;
	logic pop;

	data_t dataArray [depth];
	tokenType tokenArray [depth];

	assign write = push & ~full;	// Push into a full queue is dropped
	assign pop = ~empty & ~stall;	// Head leaves unless held by the arbiter

	always_ff @(posedge clock) begin
		if (write) begin
			dataArray[writeAddress] <= pushData;
			tokenArray[writeAddress] <= pushToken;
		end
	end

	assign valid = pop;
	assign headData = dataArray[readAddress];
	assign headToken = tokenArray[readAddress];

	ringBufferControl #(
		.entryCount(depth)
	) control0 (
		.clock(clock),
		.reset(reset),
		.writeEnable(write),
		.readEnable(pop),
		.writeAddress(writeAddress),
		.readAddress(readAddress),
		.full(full),
		.empty(empty),
		.entryNumber(entryNumber)
	);

endmodule

`default_nettype wire

/* logic/ringBufferControl.sv */
`default_nettype none

module ringBufferControl #(
	parameter int entryCount = 4
)(
	input logic clock,
	input logic reset,
	input logic writeEnable,
	input logic readEnable,
	output logic [$clog2(entryCount)-1:0] writeAddress,
	output logic [$clog2(entryCount)-1:0] readAddress,
	output logic full,
	output logic empty,
	output logic [$clog2(entryCount+1)-1:0] entryNumber
);

	localparam int addrWidth = $clog2(entryCount);
	localparam int countWidth = $clog2(entryCount + 1);

	logic [addrWidth-1:0] writePointer;
	logic [addrWidth-1:0] readPointer;
	logic [countWidth-1:0] count;

	// Pointers wrap at entryCount, which need not be a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			writePointer <= '0;
			readPointer <= '0;
			count <= '0;
		end else begin
			if (writeEnable)
				writePointer <= (writePointer == addrWidth'(entryCount - 1)) ? '0 : writePointer + 1'b1;
			if (readEnable)
				readPointer <= (readPointer == addrWidth'(entryCount - 1)) ? '0 : readPointer + 1'b1;
			case ({writeEnable, readEnable})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Push and pop together cancel
			endcase
		end
	end

	assign writeAddress = writePointer;
	assign readAddress = readPointer;
	assign full = (count == countWidth'(entryCount));
	assign empty = (count == '0);
	assign entryNumber = count;

endmodule

`default_nettype wire

/* logic/execLanePkg.sv */
`default_nettype none

package execLanePkg;

	typedef logic [31:0] data_t;	// Operand and result word
	typedef logic [3:0] index_t;	// Register number

	// Lane opcodes, MUL goes to the multiply unit
	typedef enum logic [1:0] {
		ADD = 2'd0,
		SUB = 2'd1,
		LDI = 2'd2,
		MUL = 2'd3
	} opCode_t;

	// Add unit queue payload
	typedef struct packed {
		index_t dstIndex;
		opCode_t opCode;
	} addToken_t;

	// Multiply unit queue payload
	typedef struct packed {
		index_t dstIndex;
	} mulToken_t;

endpackage

`default_nettype wire

/* logic/execLane_macros.svh */
`ifndef EXECLANE_MACROS_SVH
`define EXECLANE_MACROS_SVH

////////////////////
// Register file

// Architectural registers, indexed by index_t
`define REG_COUNT 16

////////////////////
// Result queues

`define ADD_QUEUE_DEPTH 4
`define MUL_QUEUE_DEPTH 4

////////////////////
// Multiply pipeline

// Stages between issue and the queue push
`define MUL_STAGES 2

`endif
